// File: sh_pkg.sv
`default_nettype none

package sh_pkg;

	typedef logic [31:0] sh_word_t;
	typedef logic [3:0]  sh_reg_t;
	typedef logic [31:0] sh_pc_t;

	localparam logic [4:0]  SH_NREGS = 5'd16;
	localparam logic [15:0] SH_NOP   = 16'h0009;

	// ******************************
	// Major opcodes, bits 15:12
	// ******************************
	localparam logic [3:0] SH_OP_NOP   = 4'h0;
	localparam logic [3:0] SH_OP_LOGIC = 4'h2;
	localparam logic [3:0] SH_OP_ARITH = 4'h3;
	localparam logic [3:0] SH_OP_SHIFT = 4'h4;
	localparam logic [3:0] SH_OP_MOV   = 4'h6;
	localparam logic [3:0] SH_OP_ADDI  = 4'h7;
	localparam logic [3:0] SH_OP_BR    = 4'h8;
	localparam logic [3:0] SH_OP_MOVI  = 4'hE;

	// Function field of the register forms
	localparam logic [3:0] SH_FN_CMPEQ = 4'h0;
	localparam logic [3:0] SH_FN_MOV   = 4'h3;
	localparam logic [3:0] SH_FN_SUB   = 4'h8;
	localparam logic [3:0] SH_FN_AND   = 4'h9;
	localparam logic [3:0] SH_FN_XOR   = 4'hA;
	localparam logic [3:0] SH_FN_OR    = 4'hB;
	localparam logic [3:0] SH_FN_ADD   = 4'hC;

	// Branch sub-opcodes, in the n field
	localparam logic [3:0] SH_BR_BT = 4'h9;
	localparam logic [3:0] SH_BR_BF = 4'hB;

	typedef union packed {
		struct packed {
			logic [3:0] op;
			logic [3:0] n;
			logic [3:0] m;
			logic [3:0] fn;
		} rr;
		struct packed {
			logic [3:0] op;
			logic [3:0] n;
			logic [7:0] imm;
		} ri;
	} sh_instr_u;

	typedef enum logic [3:0] {
		NOP, MOVI, MOV, ADD, SUB, CMPEQ, AND, XOR, OR, SHLL, SHLR, BT, BF
	} sh_alu_op_e;

	typedef struct packed {
		sh_alu_op_e alu;
		sh_reg_t    rn;
		sh_reg_t    rm;
		logic       use_imm;
		sh_word_t   imm;
		logic       writes_rn;
		logic       sets_t;
		logic       is_branch;
		logic       ili;
	} sh_deci_t;

	localparam sh_deci_t SH_DECI_RESET = '{
		alu: NOP, rn: '0, rm: '0, use_imm: 1'b0, imm: '0,
		writes_rn: 1'b0, sets_t: 1'b0, is_branch: 1'b0, ili: 1'b0
	};

endpackage

`default_nettype wire

// File: sh_if.sv
`timescale 1ns/1ps
`default_nettype none

// Fetch control, all valid in the same cycle
interface sh_fetch_if;
	logic word_ok;
	logic half_lo;
	logic use_saved;
	logic flush;

	modport ctrl (output word_ok, output half_lo, output use_saved, output flush);
	modport fetch (input word_ok, input half_lo, input use_saved, input flush);
endinterface

// Writeback stage register contents
interface sh_wb_if;
	logic              we;
	sh_pkg::sh_reg_t   n;
	sh_pkg::sh_word_t  data;
	sh_pkg::sh_instr_u ir;

	modport src (output we, output n, output data, output ir);
	modport dst (input we, input n, input data);
endinterface

`default_nettype wire

// File: sh_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sh_pipe_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             bus_wait,
	input  logic             br_taken,
	input  sh_pkg::sh_pc_t   br_target,
	output sh_pkg::sh_word_t bus_a,
	output logic             bus_req,
	output sh_pkg::sh_pc_t   pc,
	sh_fetch_if.ctrl         fch
);

	logic           active;
	logic           saved_ok;
	logic           pend;
	sh_pkg::sh_pc_t pend_pc;
	logic           avail;

	// Odd PC with the lower half already held in IF
	assign fch.use_saved = pc[1] & saved_ok;
	assign fch.half_lo   = pc[1];
	assign fch.flush     = br_taken;
	assign bus_req       = active & ~fch.use_saved;
	assign bus_a         = {pc[31:2], 2'b00};

	// A word arriving for a redirected fetch is dropped
	assign fch.word_ok = bus_req & ~bus_wait & ~pend;
	assign avail       = fch.word_ok | fch.use_saved;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active   <= 1'b0;
			pc       <= '0;
			saved_ok <= 1'b0;
			pend     <= 1'b0;
		end else begin
			active <= 1'b1;
			if (br_taken) begin
				// Hold a waited request steady, redirect once it completes
				if (bus_req && bus_wait) begin
					pend <= 1'b1;
				end else begin
					pc       <= br_target;
					saved_ok <= 1'b0;
				end
			end else if (pend && bus_req && !bus_wait) begin
				pc       <= pend_pc;
				pend     <= 1'b0;
				saved_ok <= 1'b0;
			end else if (avail) begin
				pc       <= pc + 32'd2;
				saved_ok <= ~pc[1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (br_taken) begin
			pend_pc <= br_target;
		end
	end

	a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bus_req && bus_wait |=> bus_req && $stable(bus_a));

endmodule

`default_nettype wire

// File: sh_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module sh_fetch (
	input  logic              clk,
	input  logic              rst_n,
	input  sh_pkg::sh_word_t  bus_di,
	input  sh_pkg::sh_pc_t    pc,
	sh_fetch_if.fetch         fch,
	output sh_pkg::sh_instr_u id_ir,
	output sh_pkg::sh_pc_t    id_pc
);

	logic [15:0]       saved_lo;
	sh_pkg::sh_instr_u new_ir;
	logic              avail;

	assign avail = fch.word_ok | fch.use_saved;

	// Upper half is the even PC, lower half the odd one
	always_comb begin
		if (fch.use_saved) begin
			new_ir = saved_lo;
		end else if (fch.half_lo) begin
			new_ir = bus_di[15:0];
		end else begin
			new_ir = bus_di[31:16];
		end
	end

	always_ff @(posedge clk) begin
		if (fch.word_ok) begin
			saved_lo <= bus_di[15:0];
		end
		id_pc <= pc;
	end

	// ******************************
	// IF/ID register
	// ******************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ir <= sh_pkg::SH_NOP;
		end else if (fch.flush || !avail) begin
			id_ir <= sh_pkg::SH_NOP;
		end else begin
			id_ir <= new_ir;
		end
	end

endmodule

`default_nettype wire

// File: sh_decode.sv
`timescale 1ns/1ps
`default_nettype none

module sh_decode (
	input  logic              clk,
	input  logic              rst_n,
	input  sh_pkg::sh_instr_u id_ir,
	input  sh_pkg::sh_pc_t    id_pc,
	input  logic              flush,
	output sh_pkg::sh_reg_t   ra_n,
	output sh_pkg::sh_reg_t   rb_n,
	input  sh_pkg::sh_word_t  ra_q,
	input  sh_pkg::sh_word_t  rb_q,
	output sh_pkg::sh_deci_t  ex_deci,
	output sh_pkg::sh_word_t  ex_a,
	output sh_pkg::sh_word_t  ex_b,
	output sh_pkg::sh_pc_t    ex_pc,
	output sh_pkg::sh_instr_u ex_ir
);

	sh_pkg::sh_deci_t deci;

	// Operand A is always Rn, operand B is Rm
	assign ra_n = id_ir.rr.n;
	assign rb_n = id_ir.rr.m;

	always_comb begin
		deci     = sh_pkg::SH_DECI_RESET;
		deci.rn  = id_ir.rr.n;
		deci.rm  = id_ir.rr.m;
		deci.imm = {{24{id_ir.ri.imm[7]}}, id_ir.ri.imm};
		deci.ili = 1'b1;
		case (id_ir.rr.op)
			sh_pkg::SH_OP_MOVI, sh_pkg::SH_OP_ADDI: begin
				deci.alu       = (id_ir.ri.op == sh_pkg::SH_OP_MOVI) ? sh_pkg::MOVI : sh_pkg::ADD;
				deci.use_imm   = 1'b1;
				deci.writes_rn = 1'b1;
				deci.ili       = 1'b0;
			end
			sh_pkg::SH_OP_MOV: begin
				if (id_ir.rr.fn == sh_pkg::SH_FN_MOV) begin
					deci.alu       = sh_pkg::MOV;
					deci.writes_rn = 1'b1;
					deci.ili       = 1'b0;
				end
			end
			sh_pkg::SH_OP_ARITH, sh_pkg::SH_OP_LOGIC: begin
				deci.ili       = 1'b0;
				deci.writes_rn = 1'b1;
				case ({id_ir.rr.op == sh_pkg::SH_OP_ARITH, id_ir.rr.fn})
					{1'b1, sh_pkg::SH_FN_ADD}:   deci.alu = sh_pkg::ADD;
					{1'b1, sh_pkg::SH_FN_SUB}:   deci.alu = sh_pkg::SUB;
					{1'b0, sh_pkg::SH_FN_AND}:   deci.alu = sh_pkg::AND;
					{1'b0, sh_pkg::SH_FN_XOR}:   deci.alu = sh_pkg::XOR;
					{1'b0, sh_pkg::SH_FN_OR}:    deci.alu = sh_pkg::OR;
					{1'b1, sh_pkg::SH_FN_CMPEQ}: begin
						deci.alu       = sh_pkg::CMPEQ;
						deci.writes_rn = 1'b0;
						deci.sets_t    = 1'b1;
					end
					default: begin
						deci.ili       = 1'b1;
						deci.writes_rn = 1'b0;
					end
				endcase
			end
			sh_pkg::SH_OP_SHIFT: begin
				if (id_ir.rr.m == 4'h0 && id_ir.rr.fn[3:1] == 3'b000) begin
					deci.alu       = id_ir.rr.fn[0] ? sh_pkg::SHLR : sh_pkg::SHLL;
					deci.writes_rn = 1'b1;
					deci.sets_t    = 1'b1;
					deci.ili       = 1'b0;
				end
			end
			sh_pkg::SH_OP_BR: begin
				// Sub-opcode in n, displacement counts half-words
				deci.imm = {{23{id_ir.ri.imm[7]}}, id_ir.ri.imm, 1'b0};
				if (id_ir.ri.n == sh_pkg::SH_BR_BT || id_ir.ri.n == sh_pkg::SH_BR_BF) begin
					deci.alu       = (id_ir.ri.n == sh_pkg::SH_BR_BT) ? sh_pkg::BT : sh_pkg::BF;
					deci.is_branch = 1'b1;
					deci.ili       = 1'b0;
				end
			end
			sh_pkg::SH_OP_NOP: begin
				deci.ili = (id_ir != sh_pkg::SH_NOP);
			end
			default: ;
		endcase
	end

	// ******************************
	// ID/EX register
	// ******************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_deci <= sh_pkg::SH_DECI_RESET;
			ex_ir   <= sh_pkg::SH_NOP;
		end else if (flush) begin
			ex_deci <= sh_pkg::SH_DECI_RESET;
			ex_ir   <= sh_pkg::SH_NOP;
		end else begin
			ex_deci <= deci;
			ex_ir   <= id_ir;
		end
	end

	always_ff @(posedge clk) begin
		ex_a  <= ra_q;
		ex_b  <= rb_q;
		ex_pc <= id_pc;
	end

endmodule

`default_nettype wire

// File: sh_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module sh_regfile (
	input  logic             clk,
	input  logic             rst_n,
	input  sh_pkg::sh_reg_t  ra_n,
	input  sh_pkg::sh_reg_t  rb_n,
	output sh_pkg::sh_word_t ra_q,
	output sh_pkg::sh_word_t rb_q,
	sh_wb_if.dst             wb
);

	sh_pkg::sh_word_t regs [sh_pkg::SH_NREGS];

	// Write-first, the WB value wins over the array
	assign ra_q = (wb.we && wb.n == ra_n) ? wb.data : regs[ra_n];
	assign rb_q = (wb.we && wb.n == rb_n) ? wb.data : regs[rb_n];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < sh_pkg::SH_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we) begin
			regs[wb.n] <= wb.data;
		end
	end

	a_wr_idx_known: assert property (@(posedge clk) disable iff (!rst_n)
		wb.we |-> !$isunknown(wb.n));

endmodule

`default_nettype wire

// File: sh_execute.sv
`timescale 1ns/1ps
`default_nettype none

module sh_execute (
	input  logic              clk,
	input  logic              rst_n,
	input  sh_pkg::sh_deci_t  ex_deci,
	input  sh_pkg::sh_word_t  ex_a,
	input  sh_pkg::sh_word_t  ex_b,
	input  sh_pkg::sh_pc_t    ex_pc,
	input  sh_pkg::sh_instr_u ex_ir,
	output logic              br_taken,
	output sh_pkg::sh_pc_t    br_target,
	output logic              ili,
	sh_wb_if.src              wb
);

	logic             t_q;
	logic             t_new;
	sh_pkg::sh_word_t op_a;
	sh_pkg::sh_word_t op_b;
	sh_pkg::sh_word_t op_bi;
	sh_pkg::sh_word_t res;

	// ******************************
	// Bypass from EX/WB
	// ******************************
	assign op_a  = (wb.we && wb.n == ex_deci.rn) ? wb.data : ex_a;
	assign op_b  = (wb.we && wb.n == ex_deci.rm) ? wb.data : ex_b;
	assign op_bi = ex_deci.use_imm ? ex_deci.imm : op_b;

	always_comb begin
		res   = op_bi;
		t_new = t_q;
		case (ex_deci.alu)
			sh_pkg::ADD:   res = op_a + op_bi;
			sh_pkg::SUB:   res = op_a - op_bi;
			sh_pkg::AND:   res = op_a & op_bi;
			sh_pkg::XOR:   res = op_a ^ op_bi;
			sh_pkg::OR:    res = op_a | op_bi;
			sh_pkg::CMPEQ: t_new = (op_a == op_bi);
			sh_pkg::SHLL: begin
				res   = {op_a[30:0], 1'b0};
				t_new = op_a[31];
			end
			sh_pkg::SHLR: begin
				res   = {1'b0, op_a[31:1]};
				t_new = op_a[0];
			end
			default: ;
		endcase
	end

	// Branch is resolved against the committed T
	assign br_taken  = ex_deci.is_branch & ((ex_deci.alu == sh_pkg::BT) ? t_q : ~t_q);
	assign br_target = ex_pc + 32'd4 + ex_deci.imm;
	assign ili       = ex_deci.ili;

	// ******************************
	// EX/WB register and T
	// ******************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			t_q   <= 1'b0;
			wb.we <= 1'b0;
			wb.ir <= sh_pkg::SH_NOP;
		end else begin
			if (ex_deci.sets_t) begin
				t_q <= t_new;
			end
			wb.we <= ex_deci.writes_rn;
			wb.ir <= ex_ir;
		end
	end

	always_ff @(posedge clk) begin
		wb.n    <= ex_deci.rn;
		wb.data <= res;
	end

	// Flush leaves two empty EX slots behind a taken branch
	a_br_squash: assert property (@(posedge clk) disable iff (!rst_n)
		br_taken |-> ex_deci.is_branch ##1
			(!ex_deci.writes_rn && !ex_deci.is_branch) [*2]);

endmodule

`default_nettype wire

// File: sh_core.sv
`timescale 1ns/1ps
`default_nettype none

module sh_core (
	input  logic             clk,
	input  logic             rst_n,
	output sh_pkg::sh_word_t bus_a,
	output logic             bus_req,
	input  logic             bus_wait,
	input  sh_pkg::sh_word_t bus_di,
	output logic             ili,
	output logic             wb_we,
	output sh_pkg::sh_reg_t  wb_n,
	output sh_pkg::sh_word_t wb_data,
	output logic [15:0]      wb_ir
);

	sh_fetch_if fch ();
	sh_wb_if    wb ();

	sh_pkg::sh_pc_t    pc;
	sh_pkg::sh_pc_t    id_pc;
	sh_pkg::sh_pc_t    ex_pc;
	sh_pkg::sh_pc_t    br_target;
	logic              br_taken;
	sh_pkg::sh_instr_u id_ir;
	sh_pkg::sh_instr_u ex_ir;
	sh_pkg::sh_reg_t   ra_n;
	sh_pkg::sh_reg_t   rb_n;
	sh_pkg::sh_word_t  ra_q;
	sh_pkg::sh_word_t  rb_q;
	sh_pkg::sh_word_t  ex_a;
	sh_pkg::sh_word_t  ex_b;
	sh_pkg::sh_deci_t  ex_deci;

	sh_pipe_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n), .bus_wait(bus_wait), .br_taken(br_taken),
		.br_target(br_target), .bus_a(bus_a), .bus_req(bus_req), .pc(pc), .fch(fch.ctrl)
	);

	sh_fetch u_fetch (
		.clk(clk), .rst_n(rst_n), .bus_di(bus_di), .pc(pc), .fch(fch.fetch),
		.id_ir(id_ir), .id_pc(id_pc)
	);

	sh_decode u_decode (
		.clk(clk), .rst_n(rst_n), .id_ir(id_ir), .id_pc(id_pc), .flush(fch.flush),
		.ra_n(ra_n), .rb_n(rb_n), .ra_q(ra_q), .rb_q(rb_q), .ex_deci(ex_deci),
		.ex_a(ex_a), .ex_b(ex_b), .ex_pc(ex_pc), .ex_ir(ex_ir)
	);

	sh_regfile u_regs (
		.clk(clk), .rst_n(rst_n), .ra_n(ra_n), .rb_n(rb_n), .ra_q(ra_q), .rb_q(rb_q),
		.wb(wb.dst)
	);

	sh_execute u_exec (
		.clk(clk), .rst_n(rst_n), .ex_deci(ex_deci), .ex_a(ex_a), .ex_b(ex_b),
		.ex_pc(ex_pc), .ex_ir(ex_ir), .br_taken(br_taken), .br_target(br_target),
		.ili(ili), .wb(wb.src)
	);

	// Register-write trace
	assign wb_we   = wb.we;
	assign wb_n    = wb.n;
	assign wb_data = wb.data;
	assign wb_ir   = wb.ir;

endmodule

`default_nettype wire

// File: tb_sh_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sh_core;

	logic              clk;
	logic              rst_n;
	logic              bus_wait;
	sh_pkg::sh_word_t  bus_a;
	logic              bus_req;
	sh_pkg::sh_word_t  bus_di;
	logic              ili;
	logic              wb_we;
	sh_pkg::sh_reg_t   wb_n;
	sh_pkg::sh_word_t  wb_data;
	logic [15:0]       wb_ir;

	sh_pkg::sh_word_t  mem [64];
	logic [15:0]       prog [$];
	sh_pkg::sh_reg_t   exp_n [$];
	sh_pkg::sh_word_t  exp_data [$];
	logic [15:0]       exp_ir [$];
	sh_pkg::sh_word_t  ref_r [16];
	logic              ref_t;
	int                exp_ili;
	logic              waits_on;
	logic [31:0]       rnd;
	int                cycles;
	int                cycle_limit;
	int                errors;
	int                tests_run;
	int                tests_failed;

	sh_core dut (
		.clk(clk), .rst_n(rst_n), .bus_a(bus_a), .bus_req(bus_req), .bus_wait(bus_wait),
		.bus_di(bus_di), .ili(ili), .wb_we(wb_we), .wb_n(wb_n), .wb_data(wb_data),
		.wb_ir(wb_ir)
	);

	// Zero-latency instruction memory, word addressed
	// Outside an accepted request the bus carries illegal codes
	assign bus_di = (bus_req && !bus_wait) ? mem[bus_a[7:2]] : 32'hFFFF_FFFF;

	always #2 clk = ~clk;

	always @(posedge clk) begin
		#1;
		if (waits_on) begin
			rnd = xorshift(rnd);
			bus_wait = (rnd[1:0] == 2'b00);
		end else begin
			bus_wait = 1'b0;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, expected writes never completed", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Both halves illegal (op F), tagged with the word index
	function automatic sh_pkg::sh_word_t fill_word(input int w);
		return {4'hF, w[11:0], 4'hF, w[11:0]};
	endfunction

	function automatic logic [15:0] instr_at(input sh_pkg::sh_pc_t pc);
		return pc[1] ? mem[pc[7:2]][15:0] : mem[pc[7:2]][31:16];
	endfunction

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", what, exp, act);
			errors++;
		end
	endtask

	task automatic check_word(input string what, input sh_pkg::sh_word_t exp,
			input sh_pkg::sh_word_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", what, exp, act);
			errors++;
		end
	endtask

	task automatic check_reg(input string what, input sh_pkg::sh_reg_t exp,
			input sh_pkg::sh_reg_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected R%0d, actual R%0d", what, exp, act);
			errors++;
		end
	endtask

	task automatic check_instr(input string what, input sh_pkg::sh_instr_u exp,
			input sh_pkg::sh_instr_u act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", what, exp, act);
			errors++;
		end
	endtask

	task automatic load_program();
		for (int w = 0; w < 64; w++) begin
			mem[w] = fill_word(w);
		end
		for (int i = 0; i < prog.size(); i++) begin
			if (i % 2 == 0) begin
				mem[i / 2][31:16] = prog[i];
			end else begin
				mem[i / 2][15:0] = prog[i];
			end
		end
	endtask

	task automatic expect_write(input sh_pkg::sh_reg_t n, input sh_pkg::sh_word_t v,
			input logic [15:0] ir);
		ref_r[n] = v;
		exp_n.push_back(n);
		exp_data.push_back(v);
		exp_ir.push_back(ir);
	endtask

	// ******************************
	// ISA interpreter
	// ******************************
	task automatic run_model();
		sh_pkg::sh_pc_t   pc;
		sh_pkg::sh_pc_t   nxt;
		logic [15:0]      ir;
		logic [3:0]       n;
		logic [3:0]       m;
		logic [3:0]       fn;
		sh_pkg::sh_word_t simm;
		logic             ill;
		logic             done;
		int               steps;
		exp_n.delete();
		exp_data.delete();
		exp_ir.delete();
		exp_ili = 0;
		ref_t = 1'b0;
		for (int i = 0; i < 16; i++) begin
			ref_r[i] = '0;
		end
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 200) begin
			ir = instr_at(pc);
			n = ir[11:8];
			m = ir[7:4];
			fn = ir[3:0];
			simm = {{24{ir[7]}}, ir[7:0]};
			ill = 1'b0;
			nxt = pc + 32'd2;
			case (ir[15:12])
				4'hE: expect_write(n, simm, ir);
				4'h7: expect_write(n, ref_r[n] + simm, ir);
				4'h6: begin
					if (fn == 4'h3) begin
						expect_write(n, ref_r[m], ir);
					end else begin
						ill = 1'b1;
					end
				end
				4'h3: begin
					case (fn)
						4'hC: expect_write(n, ref_r[n] + ref_r[m], ir);
						4'h8: expect_write(n, ref_r[n] - ref_r[m], ir);
						4'h0: ref_t = (ref_r[n] == ref_r[m]);
						default: ill = 1'b1;
					endcase
				end
				4'h2: begin
					case (fn)
						4'h9: expect_write(n, ref_r[n] & ref_r[m], ir);
						4'hA: expect_write(n, ref_r[n] ^ ref_r[m], ir);
						4'hB: expect_write(n, ref_r[n] | ref_r[m], ir);
						default: ill = 1'b1;
					endcase
				end
				4'h4: begin
					if (m == 4'h0 && fn == 4'h0) begin
						ref_t = ref_r[n][31];
						expect_write(n, ref_r[n] << 1, ir);
					end else if (m == 4'h0 && fn == 4'h1) begin
						ref_t = ref_r[n][0];
						expect_write(n, ref_r[n] >> 1, ir);
					end else begin
						ill = 1'b1;
					end
				end
				4'h8: begin
					// BT taken on T=1, BF on T=0
					if (n == 4'h9 || n == 4'hB) begin
						if ((n == 4'h9) == ref_t) begin
							nxt = pc + 32'd4 + {simm[30:0], 1'b0};
							done = (nxt == pc);
						end
					end else begin
						ill = 1'b1;
					end
				end
				4'h0: ill = (ir != 16'h0009);
				default: ill = 1'b1;
			endcase
			if (ill) begin
				exp_ili++;
			end
			pc = nxt;
			steps++;
		end
		if (!done) begin
			$display("Reference model never reached the closing branch loop");
			errors++;
		end
	endtask

	task automatic run_program(input string base, input logic waits);
		string label;
		int    got;
		int    ili_cnt;
		int    quiet;
		int    errs_before;
		label = waits ? {base, "+wait"} : base;
		errs_before = errors;
		cycle_limit += prog.size() * 8 + 50;
		@(posedge clk);
		#1 rst_n = 1'b0;
		waits_on = waits;
		load_program();
		run_model();
		@(posedge clk);
		@(negedge clk);
		check_bit({label, " bus_req in reset"}, 1'b0, bus_req);
		check_bit({label, " wb_we in reset"}, 1'b0, wb_we);
		check_bit({label, " ili in reset"}, 1'b0, ili);
		@(posedge clk);
		#1 rst_n = 1'b1;
		got = 0;
		ili_cnt = 0;
		quiet = 0;
		// A few idle cycles after the last write catch late extras
		while (quiet < 16) begin
			@(negedge clk);
			if (ili) begin
				ili_cnt++;
			end
			if (wb_we) begin
				if (got < exp_n.size()) begin
					check_reg({label, " reg"}, exp_n[got], wb_n);
					check_word({label, " data"}, exp_data[got], wb_data);
					check_instr({label, " ir"}, exp_ir[got], wb_ir);
				end else begin
					$display("%s: register write to R%0d beyond the expected %0d writes",
						label, wb_n, exp_n.size());
					errors++;
				end
				got++;
			end
			if (got >= exp_n.size()) begin
				quiet++;
			end
		end
		check_word({label, " ili count"}, exp_ili, ili_cnt);
		tests_run++;
		if (errors == errs_before) begin
			$display("%s: ok, %0d writes, %0d ili", label, got, ili_cnt);
		end else begin
			tests_failed++;
			$display("%s: failed", label);
		end
	endtask

	// ******************************
	// Directed tests
	// ******************************
	task automatic moves_and_immediates(input logic waits);
		prog = '{16'hE105, 16'hE2FE, 16'h6323, 16'h7180, 16'h74FF, 16'h6513,
			16'h89FE, 16'h8BFE};
		run_program("moves", waits);
	endtask

	task automatic dependent_alu_chain(input logic waits);
		prog = '{16'hE10F, 16'hE203, 16'h312C, 16'h3128, 16'h2129, 16'h212A,
			16'h212B, 16'h3218, 16'h6323, 16'h331C, 16'h89FE, 16'h8BFE};
		run_program("alu chain", waits);
	endtask

	// Taken BT to odd 14, BF not taken, BT not taken, BF taken to even 28
	task automatic t_flag_branches(input logic waits);
		prog = '{16'hE101, 16'hE201, 16'h3120, 16'h8902, 16'hE377, 16'hE388,
			16'hE399, 16'h8B05, 16'hE403, 16'h4401, 16'h4400, 16'h8900,
			16'h8B00, 16'hE5AA, 16'hE1F0, 16'h4100, 16'h3128, 16'h89FE, 16'h8BFE};
		run_program("branches", waits);
	endtask

	task automatic illegal_codes(input logic waits);
		prog = '{16'hE107, 16'hF123, 16'h7101, 16'h3129, 16'h6213, 16'h89FE, 16'h8BFE};
		run_program("illegal", waits);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		bus_wait = 1'b0;
		waits_on = 1'b0;
		rnd = 32'h2fa;
		cycles = 0;
		cycle_limit = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int w = 0; w < 64; w++) begin
			mem[w] = fill_word(w);
		end
		for (int pass = 0; pass < 2; pass++) begin
			moves_and_immediates(pass == 1);
			dependent_alu_chain(pass == 1);
			t_flag_branches(pass == 1);
			illegal_codes(pass == 1);
		end
		$display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
sh_pkg.sv
sh_if.sv
sh_pipe_ctrl.sv
sh_fetch.sv
sh_decode.sv
sh_regfile.sv
sh_execute.sv
sh_core.sv
tb_sh_core.sv

// File: Bender.yml
package:
  name: sh_core

sources:
  - sh_pkg.sv
  - sh_if.sv
  - sh_pipe_ctrl.sv
  - sh_fetch.sv
  - sh_decode.sv
  - sh_regfile.sv
  - sh_execute.sv
  - sh_core.sv
  - target: simulation
    files:
      - tb_sh_core.sv
